//--- run_sim.sh
#!/bin/sh
# Builds the shared read crossbar testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f shared_read_xbar_top.f \
  --top-module shared_read_xbar_tb \
  -Mdir obj_dir

./obj_dir/Vshared_read_xbar_tb

//--- shared_read_xbar_top.f
+incdir+source
source/shared_read_xbar_pkg.sv
source/read_addr_decode.sv
source/read_port_arbiter.sv
source/tag_delay_line.sv
source/banked_ram.sv
source/read_data_return.sv
source/shared_read_xbar_top.sv
sim/shared_read_xbar_properties.sv
sim/shared_read_xbar_tb.sv

//--- sim/shared_read_xbar_properties.sv
// Shared read crossbar properties
// Arbitration and reset checks, bound into the crossbar top level

`timescale 1ns/1ps
`default_nettype none

`include "shared_read_xbar_defs.svh"

module shared_read_xbar_properties (
  input logic                                  clk,
  input logic                                  rst_n,
  input logic [`NUM_FIFOS-1:0]                 rd_addr_valid,
  input logic [`NUM_FIFOS-1:0]                 rd_addr_ready,
  input logic [`NUM_FIFOS-1:0]                 rd_data_valid,
  input logic [`NUM_READ_PORTS-1:0][`NUM_FIFOS-1:0] bank_grant
);

  for (genvar f = 0; f < `NUM_FIFOS; f++) begin : gen_fifo
    // Cycles this FIFO has held valid without a grant
    int wait_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wait_cnt <= 0;
      end else if (rd_addr_valid[f] && !rd_addr_ready[f]) begin
        wait_cnt <= wait_cnt + 1;
      end else begin
        wait_cnt <= 0;
      end
    end

    a_grant_in_time: assert property (@(posedge clk) disable iff (!rst_n)
      wait_cnt < `NUM_FIFOS)
      else $error("FIFO %0d held its request too long without a grant", f);

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
      rd_addr_ready[f] |-> rd_addr_valid[f])
      else $error("FIFO %0d granted without a valid request", f);
  end

  for (genvar b = 0; b < `NUM_READ_PORTS; b++) begin : gen_bank
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(bank_grant[b]))
      else $error("Bank %0d granted more than one FIFO", b);
  end

  a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> rd_data_valid == '0)
    else $error("Read data valid raised right after reset");

endmodule

bind shared_read_xbar_top shared_read_xbar_properties u_properties (
  .clk           (clk),
  .rst_n         (rst_n),
  .rd_addr_valid (rd_addr_valid),
  .rd_addr_ready (rd_addr_ready),
  .rd_data_valid (rd_data_valid),
  .bank_grant    (bank_grant)
);

`default_nettype wire

//--- sim/shared_read_xbar_tb.sv
// Shared read crossbar testbench
// Preloads the RAM, runs directed and random read traffic from every FIFO and
// checks arbitration and returned data against a reference model

`timescale 1ns/1ps
`default_nettype none

`include "shared_read_xbar_defs.svh"

module shared_read_xbar_tb;

  localparam int Depth        = 2 ** `ADDR_WIDTH;
  localparam int Lat          = `RAM_READ_LATENCY;
  localparam int RandomCycles = 400;
  localparam int DrainLimit   = 50;

  logic                                         clk;
  logic                                         rst_n;
  logic [`NUM_FIFOS-1:0]                        rd_addr_valid;
  logic [`NUM_FIFOS-1:0]                        rd_addr_ready;
  shared_read_xbar_pkg::addr_t [`NUM_FIFOS-1:0]  rd_addr;
  logic [`NUM_FIFOS-1:0]                        rd_data_valid;
  shared_read_xbar_pkg::data_t [`NUM_FIFOS-1:0]  rd_data;
  logic                                         wr_valid;
  shared_read_xbar_pkg::addr_t                  wr_addr;
  shared_read_xbar_pkg::data_t                  wr_data;

  integer                      seed;
  int                          cycle = 0;
  // Handshakes seen in the most recent cycle
  logic [`NUM_FIFOS-1:0]       accepted = '0;
  int                          rr_model [`NUM_READ_PORTS] = '{default: 0};
  shared_read_xbar_pkg::data_t ref_mem [Depth];
  shared_read_xbar_pkg::data_t exp_word_q [`NUM_FIFOS][$];
  int                          exp_due_q [`NUM_FIFOS][$];

  shared_read_xbar_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr_ready (rd_addr_ready),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic shared_read_xbar_pkg::data_t expected_word(
    input shared_read_xbar_pkg::addr_t addr
  );
    return ref_mem[addr];
  endfunction

  // Round robin per bank: first valid FIFO at or after the model pointer wins
  function automatic logic [`NUM_FIFOS-1:0] expected_grants();
    logic [`NUM_FIFOS-1:0] grants;
    logic                  found;
    int                    f;
    grants = '0;
    for (int b = 0; b < `NUM_READ_PORTS; b++) begin
      found = 1'b0;
      for (int i = 0; i < `NUM_FIFOS; i++) begin
        f = (rr_model[b] + i) % `NUM_FIFOS;
        if (!found && rd_addr_valid[f] && (int'(rd_addr[f]) % `NUM_READ_PORTS == b)) begin
          grants[f] = 1'b1;
          found     = 1'b1;
        end
      end
    end
    return grants;
  endfunction

  function automatic int pending_reads();
    int total;
    total = 0;
    for (int f = 0; f < `NUM_FIFOS; f++) begin
      total += exp_word_q[f].size();
    end
    return total;
  endfunction

  // Outputs are settled half a cycle after the edge that drives them
  always @(negedge clk) begin : monitor
    logic [`NUM_FIFOS-1:0] exp_ready;
    logic                  due_now;
    exp_ready = expected_grants();
    assert (rd_addr_ready == exp_ready) else
      fail_run($sformatf("Mismatch at %0t: rd_addr_ready expected %b got %b",
                         $time, exp_ready, rd_addr_ready));
    for (int f = 0; f < `NUM_FIFOS; f++) begin
      due_now = (exp_due_q[f].size() > 0) && (exp_due_q[f][0] == cycle);
      assert (rd_data_valid[f] == due_now) else
        fail_run($sformatf("Mismatch at %0t: rd_data_valid[%0d] expected %b got %b",
                           $time, f, due_now, rd_data_valid[f]));
      if (due_now) begin
        assert (rd_data[f] == exp_word_q[f][0]) else
          fail_run($sformatf("Mismatch at %0t: rd_data[%0d] expected %h got %h",
                             $time, f, exp_word_q[f][0], rd_data[f]));
        void'(exp_word_q[f].pop_front());
        void'(exp_due_q[f].pop_front());
      end
      if (rd_addr_valid[f] && rd_addr_ready[f]) begin
        exp_word_q[f].push_back(expected_word(rd_addr[f]));
        exp_due_q[f].push_back(cycle + Lat);
        rr_model[int'(rd_addr[f]) % `NUM_READ_PORTS] = (f + 1) % `NUM_FIFOS;
      end
    end
    accepted = rd_addr_valid & rd_addr_ready;
  end

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  // Keeps each request in the mask up until its handshake, within limit cycles
  task automatic hold_until_accepted(input logic [`NUM_FIFOS-1:0] mask, input int limit,
                                     input logic one_per_cycle);
    logic [`NUM_FIFOS-1:0] pending;
    int                    waited;
    pending = mask;
    waited  = 0;
    while (pending != '0) begin
      next_cycle();
      waited++;
      if (one_per_cycle) begin
        assert ($countones(accepted) == 1) else
          fail_run("Contending FIFOs did not see exactly one ready in a cycle");
      end
      pending       = pending & ~accepted;
      rd_addr_valid = rd_addr_valid & ~accepted;
      if (pending != '0 && waited >= limit) begin
        fail_run($sformatf("Timeout: requests %b not accepted within %0d cycles",
                           pending, limit));
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_reads() != 0) begin
      next_cycle();
      waited++;
      if (waited > DrainLimit) begin
        fail_run("Timeout: read data never came back for accepted requests");
      end
    end
  endtask

  initial begin
    logic [`NUM_FIFOS-1:0] sel;
    seed          = 34;
    rst_n         = 1'b0;
    rd_addr_valid = '0;
    rd_addr       = '0;
    wr_valid      = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    assert (rd_data_valid == '0) else fail_run("rd_data_valid is high right after reset");

    for (int a = 0; a < Depth; a++) begin
      wr_valid   = 1'b1;
      wr_addr    = shared_read_xbar_pkg::addr_t'(a);
      wr_data    = shared_read_xbar_pkg::data_t'($random(seed));
      ref_mem[a] = wr_data;
      next_cycle();
    end
    wr_valid = 1'b0;

    // Lone read from each FIFO
    for (int f = 0; f < `NUM_FIFOS; f++) begin
      sel              = '0;
      sel[f]           = 1'b1;
      rd_addr_valid[f] = 1'b1;
      rd_addr[f]       = shared_read_xbar_pkg::addr_t'(f * 9 + 3);
      hold_until_accepted(sel, 1, 1'b0);
      wait_drain();
    end

    // Two FIFOs on different banks go through together
    rd_addr_valid = 4'b0101;
    rd_addr[0]    = shared_read_xbar_pkg::addr_t'(10);
    rd_addr[2]    = shared_read_xbar_pkg::addr_t'(21);
    hold_until_accepted(4'b0101, 1, 1'b0);
    wait_drain();

    // Every FIFO on bank 1, twice so the pointer wraps
    for (int r = 0; r < 2; r++) begin
      for (int f = 0; f < `NUM_FIFOS; f++) begin
        rd_addr[f] = shared_read_xbar_pkg::addr_t'(8 * f + 2 * r + 1);
      end
      rd_addr_valid = '1;
      hold_until_accepted('1, `NUM_FIFOS, 1'b1);
      wait_drain();
    end

    // Back-to-back reads from one FIFO
    for (int i = 0; i < 6; i++) begin
      rd_addr_valid[1] = 1'b1;
      rd_addr[1]       = shared_read_xbar_pkg::addr_t'(30 + i);
      hold_until_accepted(4'b0010, 1, 1'b0);
    end
    wait_drain();

    for (int n = 0; n < RandomCycles; n++) begin
      for (int f = 0; f < `NUM_FIFOS; f++) begin
        if (!rd_addr_valid[f] || accepted[f]) begin
          rd_addr_valid[f] = ($random(seed) % 3) != 0;
          rd_addr[f]       = shared_read_xbar_pkg::addr_t'($random(seed));
        end
      end
      next_cycle();
    end
    rd_addr_valid = rd_addr_valid & ~accepted;
    hold_until_accepted(rd_addr_valid, `NUM_FIFOS, 1'b0);
    wait_drain();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/banked_ram.sv
// Banked RAM model
// One bank per read port, interleaved on the low address bits, with a
// preload write port and a fixed read latency on every bank

`timescale 1ns/1ps
`default_nettype none

`include "shared_read_xbar_defs.svh"

module banked_ram (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                wr_valid,
  input  shared_read_xbar_pkg::addr_t                         wr_addr,
  input  shared_read_xbar_pkg::data_t                         wr_data,
  input  logic [`NUM_READ_PORTS-1:0]                          bank_rd_valid,
  input  shared_read_xbar_pkg::addr_t [`NUM_READ_PORTS-1:0]    bank_rd_addr,
  output logic [`NUM_READ_PORTS-1:0]                          bank_rd_data_valid,
  output shared_read_xbar_pkg::data_t [`NUM_READ_PORTS-1:0]    bank_rd_data
);

  localparam int BankBits = $clog2(`NUM_READ_PORTS);
  localparam int RowBits  = `ADDR_WIDTH - BankBits;
  localparam int Rows     = 2 ** RowBits;

  shared_read_xbar_pkg::bank_id_t wr_bank;

  assign wr_bank = shared_read_xbar_pkg::bank_id_t'(wr_addr % `NUM_READ_PORTS);

  for (genvar b = 0; b < `NUM_READ_PORTS; b++) begin : gen_bank
    shared_read_xbar_pkg::data_t mem [Rows];
    shared_read_xbar_pkg::data_t rd_word_q;
    logic                        rd_valid_q;

    // The upper address bits index the row inside the bank
    always_ff @(posedge clk) begin
      if (wr_valid && (wr_bank == shared_read_xbar_pkg::bank_id_t'(b))) begin
        mem[wr_addr[`ADDR_WIDTH-1:BankBits]] <= wr_data;
      end
      if (bank_rd_valid[b]) begin
        rd_word_q <= mem[bank_rd_addr[b][`ADDR_WIDTH-1:BankBits]];
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_valid_q <= 1'b0;
      end else begin
        rd_valid_q <= bank_rd_valid[b];
      end
    end

    // Sampling register counts as the first latency cycle
    tag_delay_line #(
      .NumStages (`RAM_READ_LATENCY - 1),
      .payload_t (shared_read_xbar_pkg::data_t)
    ) u_rd_data_delay (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (rd_valid_q),
      .in_data   (rd_word_q),
      .out_valid (bank_rd_data_valid[b]),
      .out_data  (bank_rd_data[b])
    );
  end

endmodule

`default_nettype wire

//--- source/read_addr_decode.sv
// Read address decode
// Routes each FIFO request to the bank named by its low address bits and
// folds the bank grants back into a per-FIFO address ready

`timescale 1ns/1ps
`default_nettype none

`include "shared_read_xbar_defs.svh"

module read_addr_decode (
  input  logic [`NUM_FIFOS-1:0]                              rd_addr_valid,
  input  shared_read_xbar_pkg::addr_t [`NUM_FIFOS-1:0]        rd_addr,
  input  logic [`NUM_READ_PORTS-1:0][`NUM_FIFOS-1:0]         bank_grant,
  output logic [`NUM_READ_PORTS-1:0][`NUM_FIFOS-1:0]         bank_req,
  output logic [`NUM_FIFOS-1:0]                              rd_addr_ready
);

  for (genvar f = 0; f < `NUM_FIFOS; f++) begin : gen_fifo
    shared_read_xbar_pkg::bank_id_t target_bank;
    logic [`NUM_READ_PORTS-1:0] fifo_grant;

    // Modulo by a power of two keeps only the bank bits, and gives bank 0
    // when there is a single port
    assign target_bank = shared_read_xbar_pkg::bank_id_t'(rd_addr[f] % `NUM_READ_PORTS);

    for (genvar b = 0; b < `NUM_READ_PORTS; b++) begin : gen_bank
      assign bank_req[b][f] = rd_addr_valid[f] &&
                              (target_bank == shared_read_xbar_pkg::bank_id_t'(b));
      assign fifo_grant[b] = bank_grant[b][f];
    end

    // Only the targeted bank can grant, so the OR is that bank's grant
    assign rd_addr_ready[f] = |fifo_grant;
  end

endmodule

`default_nettype wire

//--- source/read_data_return.sv
// Read data return path
// Tracks which FIFO won each bank read and steers the returned word back
// to that FIFO once the RAM latency has elapsed

`timescale 1ns/1ps
`default_nettype none

`include "shared_read_xbar_defs.svh"

module read_data_return (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [`NUM_READ_PORTS-1:0]                          bank_rd_valid,
  input  shared_read_xbar_pkg::fifo_id_t [`NUM_READ_PORTS-1:0] grant_fifo_id,
  input  logic [`NUM_READ_PORTS-1:0]                          bank_rd_data_valid,
  input  shared_read_xbar_pkg::data_t [`NUM_READ_PORTS-1:0]    bank_rd_data,
  output logic [`NUM_FIFOS-1:0]                               rd_data_valid,
  output shared_read_xbar_pkg::data_t [`NUM_FIFOS-1:0]         rd_data
);

  logic [`NUM_READ_PORTS-1:0]                           tag_valid;
  shared_read_xbar_pkg::fifo_id_t [`NUM_READ_PORTS-1:0] tag_id;
  // Bank b is returning data to FIFO f this cycle
  logic [`NUM_READ_PORTS-1:0][`NUM_FIFOS-1:0]          hit;

  for (genvar b = 0; b < `NUM_READ_PORTS; b++) begin : gen_bank
    tag_delay_line #(
      .NumStages (`RAM_READ_LATENCY),
      .payload_t (shared_read_xbar_pkg::fifo_id_t)
    ) u_tag_delay (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (bank_rd_valid[b]),
      .in_data   (grant_fifo_id[b]),
      .out_valid (tag_valid[b]),
      .out_data  (tag_id[b])
    );

    for (genvar f = 0; f < `NUM_FIFOS; f++) begin : gen_fifo
      assign hit[b][f] = tag_valid[b] && bank_rd_data_valid[b] &&
                         (tag_id[b] == shared_read_xbar_pkg::fifo_id_t'(f));
    end
  end

  // A FIFO has at most one read per bank in flight at a given slot, so the
  // hits for one FIFO are one-hot across banks and an OR acts as the mux
  always_comb begin
    for (int f = 0; f < `NUM_FIFOS; f++) begin
      rd_data_valid[f] = 1'b0;
      rd_data[f]       = '0;
      for (int b = 0; b < `NUM_READ_PORTS; b++) begin
        if (hit[b][f]) begin
          rd_data_valid[f] = 1'b1;
          rd_data[f]       = rd_data[f] | bank_rd_data[b];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/read_port_arbiter.sv
// Per-bank read arbiter
// Round-robin choice of one requesting FIFO per cycle, issuing its RAM read
// together with the id of the winning FIFO

`timescale 1ns/1ps
`default_nettype none

`include "shared_read_xbar_defs.svh"

module read_port_arbiter (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [`NUM_FIFOS-1:0]                         bank_req,
  input  shared_read_xbar_pkg::addr_t [`NUM_FIFOS-1:0]   rd_addr,
  output logic [`NUM_FIFOS-1:0]                         bank_grant,
  output logic                                          bank_rd_valid,
  output shared_read_xbar_pkg::addr_t                   bank_rd_addr,
  output shared_read_xbar_pkg::fifo_id_t                grant_fifo_id
);

  // FIFO with the highest priority in the current cycle
  shared_read_xbar_pkg::fifo_id_t rr_ptr;

  always_comb begin
    int idx;
    bank_grant    = '0;
    bank_rd_valid = 1'b0;
    bank_rd_addr  = '0;
    grant_fifo_id = '0;
    // Scan from the pointer and take the first requester
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      idx = (int'(rr_ptr) + i) % `NUM_FIFOS;
      if (!bank_rd_valid && bank_req[idx]) begin
        bank_rd_valid   = 1'b1;
        bank_grant[idx] = 1'b1;
        bank_rd_addr    = rd_addr[idx];
        grant_fifo_id   = shared_read_xbar_pkg::fifo_id_t'(idx);
      end
    end
  end

  // A grant is always taken since the RAM read never stalls, so the
  // pointer moves to one past the winner whenever a read is issued
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (bank_rd_valid) begin
      if (grant_fifo_id == shared_read_xbar_pkg::fifo_id_t'(`NUM_FIFOS - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_fifo_id + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/shared_read_xbar_defs.svh
// Shared read crossbar configuration
// Sizes of the FIFO set, the banked RAM and its fixed read latency

`ifndef SHARED_READ_XBAR_DEFS_SVH
`define SHARED_READ_XBAR_DEFS_SVH

// Logical FIFOs that share the RAM
`define NUM_FIFOS 4

// RAM read ports, one bank each; must be a power of two
`define NUM_READ_PORTS 2

// Word address width across the whole shared RAM
`define ADDR_WIDTH 6

`define DATA_WIDTH 16

// Cycles from a read issued at a bank to its data being valid, at least 1
`define RAM_READ_LATENCY 2

`endif

//--- source/shared_read_xbar_pkg.sv
// Shared read crossbar types
// Address, data word, FIFO index and bank index used across the design

`default_nettype none

`include "shared_read_xbar_defs.svh"

package shared_read_xbar_pkg;

  // Low log2(NUM_READ_PORTS) bits of an address select the bank
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  typedef logic [`DATA_WIDTH-1:0] data_t;

  typedef logic [$clog2(`NUM_FIFOS)-1:0] fifo_id_t;

  // A single-port RAM still needs one bit to carry a bank index
  typedef logic [((`NUM_READ_PORTS > 1) ? $clog2(`NUM_READ_PORTS) : 1)-1:0] bank_id_t;

endpackage

`default_nettype wire

//--- source/shared_read_xbar_top.sv
// Shared RAM read crossbar
// Several FIFOs issue read addresses into one banked RAM; per-bank arbiters
// pick a FIFO each cycle and the data returns to it after a fixed latency

`timescale 1ns/1ps
`default_nettype none

`include "shared_read_xbar_defs.svh"

module shared_read_xbar_top (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [`NUM_FIFOS-1:0]                         rd_addr_valid,
  output logic [`NUM_FIFOS-1:0]                         rd_addr_ready,
  input  shared_read_xbar_pkg::addr_t [`NUM_FIFOS-1:0]   rd_addr,
  output logic [`NUM_FIFOS-1:0]                         rd_data_valid,
  output shared_read_xbar_pkg::data_t [`NUM_FIFOS-1:0]   rd_data,
  input  logic                                          wr_valid,
  input  shared_read_xbar_pkg::addr_t                   wr_addr,
  input  shared_read_xbar_pkg::data_t                   wr_data
);

  logic [`NUM_READ_PORTS-1:0][`NUM_FIFOS-1:0]             bank_req;
  logic [`NUM_READ_PORTS-1:0][`NUM_FIFOS-1:0]             bank_grant;
  logic [`NUM_READ_PORTS-1:0]                             bank_rd_valid;
  shared_read_xbar_pkg::addr_t [`NUM_READ_PORTS-1:0]      bank_rd_addr;
  shared_read_xbar_pkg::fifo_id_t [`NUM_READ_PORTS-1:0]   grant_fifo_id;
  logic [`NUM_READ_PORTS-1:0]                             bank_rd_data_valid;
  shared_read_xbar_pkg::data_t [`NUM_READ_PORTS-1:0]      bank_rd_data;

  read_addr_decode u_decode (
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .bank_grant    (bank_grant),
    .bank_req      (bank_req),
    .rd_addr_ready (rd_addr_ready)
  );

  // One arbiter per read port
  for (genvar b = 0; b < `NUM_READ_PORTS; b++) begin : gen_arbiter
    read_port_arbiter u_arbiter (
      .clk           (clk),
      .rst_n         (rst_n),
      .bank_req      (bank_req[b]),
      .rd_addr       (rd_addr),
      .bank_grant    (bank_grant[b]),
      .bank_rd_valid (bank_rd_valid[b]),
      .bank_rd_addr  (bank_rd_addr[b]),
      .grant_fifo_id (grant_fifo_id[b])
    );
  end

  banked_ram u_ram (
    .clk                (clk),
    .rst_n              (rst_n),
    .wr_valid           (wr_valid),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .bank_rd_valid      (bank_rd_valid),
    .bank_rd_addr       (bank_rd_addr),
    .bank_rd_data_valid (bank_rd_data_valid),
    .bank_rd_data       (bank_rd_data)
  );

  read_data_return u_return (
    .clk                (clk),
    .rst_n              (rst_n),
    .bank_rd_valid      (bank_rd_valid),
    .grant_fifo_id      (grant_fifo_id),
    .bank_rd_data_valid (bank_rd_data_valid),
    .bank_rd_data       (bank_rd_data),
    .rd_data_valid      (rd_data_valid),
    .rd_data            (rd_data)
  );

endmodule

`default_nettype wire

//--- source/tag_delay_line.sv
// Valid-qualified delay line
// Carries a payload through a fixed number of register stages; the payload
// registers only load when the stage ahead of them holds valid data

`timescale 1ns/1ps
`default_nettype none

module tag_delay_line #(
  parameter int  NumStages = 1,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  if (NumStages == 0) begin : gen_no_stages
    assign out_valid = in_valid;
    assign out_data  = in_data;
  end else begin : gen_stages
    logic [NumStages-1:0] stage_valid;
    payload_t             stage_data [NumStages];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        stage_valid <= '0;
      end else begin
        stage_valid[0] <= in_valid;
        for (int i = 1; i < NumStages; i++) begin
          stage_valid[i] <= stage_valid[i-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      if (in_valid) begin
        stage_data[0] <= in_data;
      end
      for (int i = 1; i < NumStages; i++) begin
        if (stage_valid[i-1]) begin
          stage_data[i] <= stage_data[i-1];
        end
      end
    end

    assign out_valid = stage_valid[NumStages-1];
    assign out_data  = stage_data[NumStages-1];
  end

endmodule

`default_nettype wire
